// File: sources.f
+incdir+hw
hw/cpuPkg.sv
hw/cpuCtrl.sv
hw/regFile.sv
hw/aluUnit.sv
hw/pcIr.sv
hw/busMemIo.sv
hw/cpuTop.sv
sim/cpuTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := cpuTb
FILELIST  := sources.f
BUILD_DIR := obj_dir
FLAGS     := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LINTFLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/cpuTb.sv
/* Testbench for the shared-bus CPU with a memory model, program builder,
   directed instruction tests, compare tasks and a cycle watchdog */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module cpuTb;

    import cpuPkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int MEM_N        = 256;

    logic               clk;
    logic               reset;
    logic               stop;
    logic [`WORD_W-1:0] inPort;
    logic [`WORD_W-1:0] memRdData;
    logic               run;
    logic               memRead;
    logic               memWrite;
    logic [`ADDR_W-1:0] memAddr;
    logic [`WORD_W-1:0] memWrData;
    logic [`WORD_W-1:0] outPort;

    logic [`WORD_W-1:0] mem [MEM_N];
    logic [31:0]        lfsr;
    logic [`ADDR_W-1:0] wrAddr;
    logic [`WORD_W-1:0] wrData;
    int                 wrCount;
    int                 mismatches = 0;
    int                 failures = 0;
    int                 budget = 0;
    int                 cycles = 0;

    cpuTop i_cpuTop (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Memory reads are combinational, writes land on the clock edge
    assign memRdData = mem[memAddr[7:0]];

    always @(posedge clk) begin
        if (!reset && memWrite) begin
            mem[memAddr[7:0]] = memWrData;
            wrCount = wrCount + 1;
            wrAddr  = memAddr;
            wrData  = memWrData;
        end
    end

    // Limit grows with every program loaded
    initial begin
        while (cycles <= 2 * budget + 100) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the CPU never reached its end address", cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic checkWord(input string name, input logic [`WORD_W-1:0] got,
                             input logic [`WORD_W-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsrStep();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsrStep()};
        end
        return r;
    endfunction

    function automatic logic [`WORD_W-1:0] sext(input logic [`CONST_W-1:0] c);
        return {{(`WORD_W-`CONST_W){c[`CONST_W-1]}}, c};
    endfunction

    function automatic logic [`WORD_W-1:0] iWord(input logic [`OP_W-1:0] op,
            input logic [`REG_W-1:0] ra, input logic [`REG_W-1:0] rb,
            input logic [`CONST_W-1:0] c);
        instrWord_u w;
        w.iForm.op       = op;
        w.iForm.ra       = ra;
        w.iForm.rb       = rb;
        w.iForm.constVal = c;
        return w;
    endfunction

    function automatic logic [`WORD_W-1:0] rWord(input logic [`OP_W-1:0] op,
            input logic [`REG_W-1:0] ra, input logic [`REG_W-1:0] rb,
            input logic [`REG_W-1:0] rc);
        instrWord_u w;
        w.rForm.op     = op;
        w.rForm.ra     = ra;
        w.rForm.rb     = rb;
        w.rForm.rc     = rc;
        w.rForm.unused = '0;
        return w;
    endfunction

    // Expected results from the operation rules
    function automatic logic [`WORD_W-1:0] aluModel(input logic [`OP_W-1:0] op,
            input logic [`WORD_W-1:0] a, input logic [`WORD_W-1:0] b);
        case (op)
            `OP_ADD, `OP_ADDI: return a + b;
            `OP_SUB:           return a - b;
            `OP_AND, `OP_ANDI: return a & b;
            `OP_OR, `OP_ORI:   return a | b;
            `OP_SHL:           return a << b[4:0];
            `OP_SHR:           return a >> b[4:0];
            default:           return '0;
        endcase
    endfunction

    function automatic logic condTaken(input logic [1:0] cond, input logic [`WORD_W-1:0] v);
        case (cond)
            `BR_ZR:  return v == '0;
            `BR_NZ:  return v != '0;
            `BR_PL:  return !v[`WORD_W-1];
            default: return v[`WORD_W-1];
        endcase
    endfunction

    // Unknown opcode fill acts as a no-op that falls through
    task automatic clearMem();
        for (int a = 0; a < MEM_N; a++) begin
            mem[a] = {5'h1F, 19'h0, a[7:0]};
        end
        wrCount = 0;
    endtask

    task automatic runProgram(input int endAddr, input int stopAt, input int stopLen);
        int                 n;
        logic               firstFetch;
        logic [`WORD_W-1:0] held;
        budget += RESET_CYCLES + 8 * (endAddr + 1) + stopLen;
        @(negedge clk);
        reset = 1'b1;
        stop  = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            checkBit("memRead", memRead, 1'b0);
            checkBit("memWrite", memWrite, 1'b0);
        end
        reset = 1'b0;
        @(negedge clk);
        checkBit("run", run, 1'b1);
        n = 1;
        firstFetch = 1'b1;
        // Done once the word after the program is fetched
        while (!(memRead && memAddr == 32'(endAddr))) begin
            if (memRead && firstFetch) begin
                checkWord("memAddr", memAddr, '0);
                firstFetch = 1'b0;
            end
            if (n == stopAt) begin
                stop = 1'b1;
                held = outPort;
                repeat (stopLen) begin
                    @(negedge clk);
                    checkBit("run", run, 1'b0);
                    checkBit("memRead", memRead, 1'b0);
                    checkBit("memWrite", memWrite, 1'b0);
                    checkWord("outPort", outPort, held);
                end
                stop = 1'b0;
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic testResetFetch();
        clearMem();
        mem[0] = iWord(`OP_LDI, 4'd1, 4'd0, 19'h12345);
        mem[1] = iWord(`OP_OUT, 4'd1, 4'd0, 19'h0);
        runProgram(2, 0, 0);
        checkWord("outPort", outPort, sext(19'h12345));
    endtask

    task automatic aluCase(input logic [`OP_W-1:0] op);
        logic [`CONST_W-1:0] a;
        logic [`CONST_W-1:0] b;
        a = randBits(`CONST_W);
        b = randBits(`CONST_W);
        clearMem();
        mem[0] = iWord(`OP_LDI, 4'd1, 4'd0, a);
        mem[1] = iWord(`OP_LDI, 4'd2, 4'd0, b);
        if (op == `OP_ADDI || op == `OP_ANDI || op == `OP_ORI) begin
            mem[2] = iWord(op, 4'd3, 4'd1, b);
        end else begin
            mem[2] = rWord(op, 4'd3, 4'd1, 4'd2);
        end
        mem[3] = iWord(`OP_OUT, 4'd3, 4'd0, 19'h0);
        runProgram(4, 0, 0);
        checkWord("outPort", outPort, aluModel(op, sext(a), sext(b)));
    endtask

    task automatic testAlu();
        logic [`OP_W-1:0] ops [9];
        ops = '{`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_SHL, `OP_SHR,
                `OP_ADDI, `OP_ANDI, `OP_ORI};
        for (int i = 0; i < 9; i++) begin
            aluCase(ops[i]);
        end
    endtask

    // Store at r2 + 5, load back with a nonzero r0 as base
    task automatic testLoadStore(input int stopAt, input int stopLen);
        logic [`CONST_W-1:0] v;
        v = randBits(`CONST_W);
        clearMem();
        mem[0] = iWord(`OP_LDI, 4'd1, 4'd0, v);
        mem[1] = iWord(`OP_LDI, 4'd2, 4'd0, 19'h70);
        mem[2] = iWord(`OP_LDI, 4'd0, 4'd0, 19'h33);
        mem[3] = iWord(`OP_ST, 4'd1, 4'd2, 19'h5);
        mem[4] = iWord(`OP_LD, 4'd4, 4'd0, 19'h75);
        mem[5] = iWord(`OP_OUT, 4'd4, 4'd0, 19'h0);
        runProgram(6, stopAt, stopLen);
        if (wrCount != 1) begin
            failures++;
            $display("Expected exactly one memory write but saw %0d", wrCount);
        end
        checkWord("memAddr", wrAddr, 32'h75);
        checkWord("memWrData", wrData, sext(v));
        checkWord("outPort", outPort, sext(v));
    endtask

    // Not taken outs r2 then jr to the end, taken lands on out r3
    task automatic branchCase(input logic [1:0] cond, input logic [`CONST_W-1:0] val);
        clearMem();
        mem[0] = iWord(`OP_LDI, 4'd1, 4'd0, val);
        mem[1] = iWord(`OP_LDI, 4'd2, 4'd0, 19'h0AA);
        mem[2] = iWord(`OP_LDI, 4'd3, 4'd0, 19'h0BB);
        mem[3] = iWord(`OP_LDI, 4'd4, 4'd0, 19'd16);
        mem[4] = iWord(`OP_BR, 4'd1, 4'd0, {17'd0, cond} + 19'd4);
        mem[5] = iWord(`OP_OUT, 4'd2, 4'd0, 19'h0);
        mem[6] = iWord(`OP_JR, 4'd4, 4'd0, 19'h0);
        mem[9 + int'(cond)] = iWord(`OP_OUT, 4'd3, 4'd0, 19'h0);
        runProgram(16, 0, 0);
        checkWord("outPort", outPort, condTaken(cond, sext(val)) ? 32'hBB : 32'hAA);
    endtask

    task automatic testBranches();
        logic [17:0]         r;
        logic [`CONST_W-1:0] pos;
        logic [`CONST_W-1:0] neg;
        r   = randBits(18);
        pos = {1'b0, r | 18'h1};
        neg = {1'b1, r};
        branchCase(`BR_ZR, '0);
        branchCase(`BR_ZR, pos);
        branchCase(`BR_NZ, pos);
        branchCase(`BR_NZ, '0);
        branchCase(`BR_PL, pos);
        branchCase(`BR_PL, neg);
        branchCase(`BR_MI, neg);
        branchCase(`BR_MI, pos);
    endtask

    // Link is the address after jal, word 2 clobbers it if no jump
    task automatic testJal();
        clearMem();
        mem[0] = iWord(`OP_LDI, 4'd5, 4'd0, 19'd6);
        mem[1] = iWord(`OP_JAL, 4'd7, 4'd5, 19'h0);
        mem[2] = iWord(`OP_LDI, 4'd7, 4'd0, 19'h55);
        mem[6] = iWord(`OP_OUT, 4'd7, 4'd0, 19'h0);
        runProgram(7, 0, 0);
        checkWord("outPort", outPort, 32'd2);
    endtask

    task automatic testInPort();
        logic [`WORD_W-1:0] v;
        v = randBits(32);
        @(negedge clk);
        inPort = v;
        clearMem();
        mem[0] = iWord(`OP_IN, 4'd8, 4'd0, 19'h0);
        mem[1] = iWord(`OP_OUT, 4'd8, 4'd0, 19'h0);
        runProgram(2, 0, 0);
        checkWord("outPort", outPort, v);
    endtask

    initial begin
        reset  = 1'b1;
        stop   = 1'b0;
        inPort = '0;
        lfsr   = 32'd84579;
        testResetFetch();
        testAlu();
        testLoadStore(0, 0);
        testBranches();
        testJal();
        testInPort();
        // Stop once on the st memory write and once on the ld memory read
        testLoadStore(25, 6);
        testLoadStore(32, 5);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/cpuTop.sv
/* CPU top level wiring the control FSM to the datapath blocks */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module cpuTop (
    input  logic               clk,
    input  logic               reset,
    input  logic               stop,
    input  logic [`WORD_W-1:0] inPort,
    input  logic [`WORD_W-1:0] memRdData,
    output logic               run,
    output logic               memRead,
    output logic               memWrite,
    output logic [`ADDR_W-1:0] memAddr,
    output logic [`WORD_W-1:0] memWrData,
    output logic [`WORD_W-1:0] outPort
);

    cpuPkg::instrWord_u ir;

    logic [`WORD_W-1:0] bus;
    logic [`WORD_W-1:0] regValue;
    logic [`WORD_W-1:0] zValue;
    logic [`WORD_W-1:0] pcValue;
    logic [`WORD_W-1:0] cValue;
    logic [`ALU_W-1:0]  aluOp;

    // Bus sources
    logic pcOut;
    logic mdrOut;
    logic zOut;
    logic rOut;
    logic cOut;
    logic inPortOut;

    // Destinations and register selects
    logic marIn;
    logic mdrIn;
    logic outPortIn;
    logic yIn;
    logic zIn;
    logic rIn;
    logic gra;
    logic grb;
    logic grc;
    logic baOut;
    logic pcIn;
    logic incPc;
    logic irIn;
    logic conIn;

    cpuCtrl  i_cpuCtrl  (.*);
    regFile  i_regFile  (.*);
    aluUnit  i_aluUnit  (.*);
    pcIr     i_pcIr     (.*);
    busMemIo i_busMemIo (.*);

endmodule

`default_nettype wire

// File: hw/busMemIo.sv
/* Shared bus multiplexer with MAR, MDR and the in and out port registers */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module busMemIo (
    input  logic               clk,
    input  logic               reset,
    input  logic               pcOut,
    input  logic               mdrOut,
    input  logic               zOut,
    input  logic               rOut,
    input  logic               cOut,
    input  logic               inPortOut,
    input  logic               marIn,
    input  logic               mdrIn,
    input  logic               outPortIn,
    input  logic               memRead,
    input  logic [`WORD_W-1:0] pcValue,
    input  logic [`WORD_W-1:0] regValue,
    input  logic [`WORD_W-1:0] zValue,
    input  logic [`WORD_W-1:0] cValue,
    input  logic [`WORD_W-1:0] inPort,
    input  logic [`WORD_W-1:0] memRdData,
    output logic [`WORD_W-1:0] bus,
    output logic [`WORD_W-1:0] outPort,
    output logic [`WORD_W-1:0] memWrData,
    output logic [`ADDR_W-1:0] memAddr
);

    logic [`ADDR_W-1:0] mar;
    logic [`WORD_W-1:0] mdr;
    logic [`WORD_W-1:0] inPortQ;

    // One-hot AND-OR mux, zero when nothing drives
    assign bus = ({`WORD_W{pcOut}}     & pcValue)
               | ({`WORD_W{mdrOut}}    & mdr)
               | ({`WORD_W{zOut}}      & zValue)
               | ({`WORD_W{rOut}}      & regValue)
               | ({`WORD_W{cOut}}      & cValue)
               | ({`WORD_W{inPortOut}} & inPortQ);

    assign memAddr   = mar;
    assign memWrData = mdr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mar     <= '0;
            mdr     <= '0;
            inPortQ <= '0;
            outPort <= '0;
        end else begin
            inPortQ <= inPort;
            if (marIn) begin
                mar <= bus[`ADDR_W-1:0];
            end
            // Memory data wins during a read cycle
            if (mdrIn) begin
                mdr <= memRead ? memRdData : bus;
            end
            if (outPortIn) begin
                outPort <= bus;
            end
        end
    end

    // Only one source may drive the bus
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({pcOut, mdrOut, zOut, rOut, cOut, inPortOut}))
        else $error("bus driven by more than one source");

endmodule

`default_nettype wire

// File: hw/pcIr.sv
/* Program counter, instruction register, sign-extended constant
   and the branch condition flag */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module pcIr (
    input  logic               clk,
    input  logic               reset,
    input  logic               pcIn,
    input  logic               incPc,
    input  logic               irIn,
    input  logic               conIn,
    input  logic [`WORD_W-1:0] bus,
    output cpuPkg::instrWord_u ir,
    output logic [`WORD_W-1:0] pcValue,
    output logic [`WORD_W-1:0] cValue
);

    logic [`WORD_W-1:0] pc;
    logic               conFlag;
    logic               condMet;
    logic               isBranch;

    assign pcValue  = pc;
    assign isBranch = (ir.iForm.op == `OP_BR);
    assign cValue   = {{(`WORD_W-`CONST_W){ir.iForm.constVal[`CONST_W-1]}}, ir.iForm.constVal};

    // Condition test against the register on the bus
    always_comb begin
        case (ir.iForm.constVal[1:0])
            `BR_ZR: condMet = (bus == '0);
            `BR_NZ: condMet = (bus != '0);
            `BR_PL: condMet = !bus[`WORD_W-1];
            `BR_MI: condMet = bus[`WORD_W-1];
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc      <= '0;
            ir      <= '0;
            conFlag <= 1'b0;
        end else begin
            // Branches only load when the latched condition held
            if (pcIn && (conFlag || !isBranch)) begin
                pc <= bus;
            end else if (incPc) begin
                pc <= pc + 1'b1;
            end
            if (irIn) begin
                ir <= bus;
            end
            if (conIn) begin
                conFlag <= condMet;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/aluUnit.sv
/* Y operand register, ALU operations and Z result register */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module aluUnit (
    input  logic               clk,
    input  logic               reset,
    input  logic               yIn,
    input  logic               zIn,
    input  logic [`ALU_W-1:0]  aluOp,
    input  logic [`WORD_W-1:0] bus,
    output logic [`WORD_W-1:0] zValue
);

    localparam int SH_W = $clog2(`WORD_W);

    logic [`WORD_W-1:0] y;
    logic [`WORD_W-1:0] z;
    logic [`WORD_W-1:0] result;
    logic [SH_W-1:0]    shamt;

    // Shift count from the low bus bits
    assign shamt  = bus[SH_W-1:0];
    assign zValue = z;

    // Y is the left operand, the bus the right one
    always_comb begin
        case (aluOp)
            `ALU_ADD: result = y + bus;
            `ALU_SUB: result = y - bus;
            `ALU_AND: result = y & bus;
            `ALU_OR:  result = y | bus;
            `ALU_SHL: result = y << shamt;
            `ALU_SHR: result = y >> shamt;
            default:  result = bus;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            y <= '0;
            z <= '0;
        end else begin
            if (yIn) begin
                y <= bus;
            end
            if (zIn) begin
                z <= result;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/regFile.sv
/* Sixteen general registers with select-and-encode from the IR fields */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module regFile (
    input  logic               clk,
    input  logic               reset,
    input  logic               rIn,
    input  logic               gra,
    input  logic               grb,
    input  logic               grc,
    input  logic               baOut,
    input  cpuPkg::instrWord_u ir,
    input  logic [`WORD_W-1:0] bus,
    output logic [`WORD_W-1:0] regValue
);

    logic [`WORD_W-1:0] regs [`REG_N];
    logic [`REG_W-1:0]  sel;

    // Select and encode
    always_comb begin
        if (gra) begin
            sel = ir.rForm.ra;
        end else if (grb) begin
            sel = ir.rForm.rb;
        end else if (grc) begin
            sel = ir.rForm.rc;
        end else begin
            sel = '0;
        end
    end

    // Base address mode treats r0 as zero
    assign regValue = (baOut && sel == '0) ? '0 : regs[sel];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (rIn) begin
            regs[sel] <= bus;
        end
    end

    // FSM raises at most one field select per step
    assert property (@(posedge clk) disable iff (reset) $onehot0({gra, grb, grc}))
        else $error("more than one register field selected");

endmodule

`default_nettype wire

// File: hw/cpuCtrl.sv
/* Control FSM sequencing fetch and execute, one state per clock,
   driving every bus and register strobe */
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module cpuCtrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               stop,
    input  cpuPkg::instrWord_u ir,
    output logic               run,
    output logic               pcOut,
    output logic               mdrOut,
    output logic               zOut,
    output logic               rOut,
    output logic               cOut,
    output logic               inPortOut,
    output logic               marIn,
    output logic               mdrIn,
    output logic               outPortIn,
    output logic               memRead,
    output logic               memWrite,
    output logic               yIn,
    output logic               zIn,
    output logic               rIn,
    output logic               gra,
    output logic               grb,
    output logic               grc,
    output logic               baOut,
    output logic               pcIn,
    output logic               incPc,
    output logic               irIn,
    output logic               conIn,
    output logic [`ALU_W-1:0]  aluOp
);

    localparam logic [2:0] FETCH0 = 3'd0;
    localparam logic [2:0] FETCH1 = 3'd1;
    localparam logic [2:0] FETCH2 = 3'd2;
    localparam logic [2:0] EXEC1  = 3'd3;
    localparam logic [2:0] EXEC2  = 3'd4;
    localparam logic [2:0] EXEC3  = 3'd5;
    localparam logic [2:0] EXEC4  = 3'd6;
    localparam logic [2:0] EXEC5  = 3'd7;

    logic [2:0]        state;
    logic [2:0]        nextState;
    logic [`OP_W-1:0]  opcode;
    logic [`ALU_W-1:0] opAlu;

    assign opcode = ir.rForm.op;
    assign run    = !(reset || stop);

    // Address math for memory and branch always adds
    always_comb begin
        case (opcode)
            `OP_ADD, `OP_ADDI, `OP_LD, `OP_LDI, `OP_ST, `OP_BR: opAlu = `ALU_ADD;
            `OP_SUB:           opAlu = `ALU_SUB;
            `OP_AND, `OP_ANDI: opAlu = `ALU_AND;
            `OP_OR, `OP_ORI:   opAlu = `ALU_OR;
            `OP_SHL:           opAlu = `ALU_SHL;
            `OP_SHR:           opAlu = `ALU_SHR;
            default:           opAlu = `ALU_NOP;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH0;
        end else begin
            state <= nextState;
        end
    end

    // Execute steps are decoded from the IR loaded at the end of fetch2
    always_comb begin
        nextState = state;
        pcOut     = 1'b0;
        mdrOut    = 1'b0;
        zOut      = 1'b0;
        rOut      = 1'b0;
        cOut      = 1'b0;
        inPortOut = 1'b0;
        marIn     = 1'b0;
        mdrIn     = 1'b0;
        outPortIn = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        yIn       = 1'b0;
        zIn       = 1'b0;
        rIn       = 1'b0;
        gra       = 1'b0;
        grb       = 1'b0;
        grc       = 1'b0;
        baOut     = 1'b0;
        pcIn      = 1'b0;
        incPc     = 1'b0;
        irIn      = 1'b0;
        conIn     = 1'b0;
        aluOp     = `ALU_NOP;
        // Stop freezes the state with all strobes low
        if (!stop) begin
            case (state)
                FETCH0: begin
                    pcOut     = 1'b1;
                    marIn     = 1'b1;
                    incPc     = 1'b1;
                    nextState = FETCH1;
                end
                FETCH1: begin
                    memRead   = 1'b1;
                    mdrIn     = 1'b1;
                    nextState = FETCH2;
                end
                FETCH2: begin
                    mdrOut    = 1'b1;
                    irIn      = 1'b1;
                    nextState = EXEC1;
                end
                EXEC1: begin
                    nextState = EXEC2;
                    case (opcode)
                        `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_SHL, `OP_SHR,
                        `OP_ADDI, `OP_ANDI, `OP_ORI: begin
                            grb  = 1'b1;
                            rOut = 1'b1;
                            yIn  = 1'b1;
                        end
                        `OP_LD, `OP_LDI, `OP_ST: begin
                            grb   = 1'b1;
                            rOut  = 1'b1;
                            baOut = 1'b1;
                            yIn   = 1'b1;
                        end
                        `OP_BR: begin
                            gra   = 1'b1;
                            rOut  = 1'b1;
                            conIn = 1'b1;
                        end
                        `OP_JAL: begin
                            pcOut = 1'b1;
                            gra   = 1'b1;
                            rIn   = 1'b1;
                        end
                        `OP_JR: begin
                            gra       = 1'b1;
                            rOut      = 1'b1;
                            pcIn      = 1'b1;
                            nextState = FETCH0;
                        end
                        `OP_IN: begin
                            inPortOut = 1'b1;
                            gra       = 1'b1;
                            rIn       = 1'b1;
                            nextState = FETCH0;
                        end
                        `OP_OUT: begin
                            gra       = 1'b1;
                            rOut      = 1'b1;
                            outPortIn = 1'b1;
                            nextState = FETCH0;
                        end
                        default: begin
                            // Unknown opcode, this step already fetches the next word
                            pcOut     = 1'b1;
                            marIn     = 1'b1;
                            incPc     = 1'b1;
                            nextState = FETCH1;
                        end
                    endcase
                end
                EXEC2: begin
                    nextState = EXEC3;
                    case (opcode)
                        `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_SHL, `OP_SHR: begin
                            grc   = 1'b1;
                            rOut  = 1'b1;
                            zIn   = 1'b1;
                            aluOp = opAlu;
                        end
                        `OP_ADDI, `OP_ANDI, `OP_ORI, `OP_LD, `OP_LDI, `OP_ST: begin
                            cOut  = 1'b1;
                            zIn   = 1'b1;
                            aluOp = opAlu;
                        end
                        `OP_BR: begin
                            pcOut = 1'b1;
                            yIn   = 1'b1;
                        end
                        `OP_JAL: begin
                            grb       = 1'b1;
                            rOut      = 1'b1;
                            pcIn      = 1'b1;
                            nextState = FETCH0;
                        end
                        default: nextState = FETCH0;
                    endcase
                end
                EXEC3: begin
                    nextState = FETCH0;
                    case (opcode)
                        `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_SHL, `OP_SHR,
                        `OP_ADDI, `OP_ANDI, `OP_ORI, `OP_LDI: begin
                            zOut = 1'b1;
                            gra  = 1'b1;
                            rIn  = 1'b1;
                        end
                        `OP_LD, `OP_ST: begin
                            zOut      = 1'b1;
                            marIn     = 1'b1;
                            nextState = EXEC4;
                        end
                        `OP_BR: begin
                            cOut      = 1'b1;
                            zIn       = 1'b1;
                            aluOp     = opAlu;
                            nextState = EXEC4;
                        end
                        default: ;
                    endcase
                end
                EXEC4: begin
                    nextState = FETCH0;
                    case (opcode)
                        `OP_LD: begin
                            memRead   = 1'b1;
                            mdrIn     = 1'b1;
                            nextState = EXEC5;
                        end
                        `OP_ST: begin
                            gra       = 1'b1;
                            rOut      = 1'b1;
                            mdrIn     = 1'b1;
                            nextState = EXEC5;
                        end
                        // Target only lands if the condition flag is set
                        `OP_BR: begin
                            zOut = 1'b1;
                            pcIn = 1'b1;
                        end
                        default: ;
                    endcase
                end
                EXEC5: begin
                    nextState = FETCH0;
                    if (opcode == `OP_LD) begin
                        mdrOut = 1'b1;
                        gra    = 1'b1;
                        rIn    = 1'b1;
                    end else if (opcode == `OP_ST) begin
                        memWrite = 1'b1;
                    end
                end
            endcase
        end
    end

    // Memory is never read and written in the same cycle
    assert property (@(posedge clk) disable iff (reset) !(memRead && memWrite))
        else $error("memRead and memWrite high together");

endmodule

`default_nettype wire

// File: hw/cpuPkg.sv
/* Instruction word union with its register and immediate layouts */
`default_nettype none

`include "cpu_cfg.svh"

package cpuPkg;

    // Three-register layout
    typedef struct packed {
        logic [`OP_W-1:0]                      op;
        logic [`REG_W-1:0]                     ra;
        logic [`REG_W-1:0]                     rb;
        logic [`REG_W-1:0]                     rc;
        logic [`WORD_W-`OP_W-3*`REG_W-1:0]     unused;
    } rForm_s;

    // Two registers and a signed constant
    typedef struct packed {
        logic [`OP_W-1:0]    op;
        logic [`REG_W-1:0]   ra;
        logic [`REG_W-1:0]   rb;
        logic [`CONST_W-1:0] constVal;
    } iForm_s;

    typedef union packed {
        rForm_s rForm;
        iForm_s iForm;
    } instrWord_u;

endpackage

`default_nettype wire

// File: hw/cpu_cfg.svh
/* Datapath widths, instruction opcodes, ALU operation codes and branch
   condition codes for the shared-bus CPU */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath widths
`define WORD_W  32
`define ADDR_W  32
`define REG_N   16
`define REG_W   4
`define OP_W    5
`define CONST_W 19

// Opcodes in bits 31..27
`define OP_LD   5'd0
`define OP_LDI  5'd1
`define OP_ST   5'd2
`define OP_ADD  5'd3
`define OP_SUB  5'd4
`define OP_AND  5'd5
`define OP_OR   5'd6
`define OP_SHR  5'd7
`define OP_SHL  5'd9
`define OP_ADDI 5'd12
`define OP_ANDI 5'd13
`define OP_ORI  5'd14
`define OP_BR   5'd19
`define OP_JR   5'd20
`define OP_JAL  5'd21
`define OP_IN   5'd22
`define OP_OUT  5'd23

// ALU operations
`define ALU_W   3
`define ALU_NOP 3'd0
`define ALU_ADD 3'd1
`define ALU_SUB 3'd2
`define ALU_AND 3'd3
`define ALU_OR  3'd4
`define ALU_SHL 3'd5
`define ALU_SHR 3'd6

// Branch conditions, taken from the low two constant bits
`define BR_ZR 2'd0
`define BR_NZ 2'd1
`define BR_PL 2'd2
`define BR_MI 2'd3

`endif
